// File: ram_flops_tile.f
hw/ram_tile_pkg.sv
hw/ram_wr_decode.sv
hw/ram_storage.sv
hw/ram_rd_port.sv
hw/ram_flops_tile.sv
verif/ram_flops_tile_chk.sv
verif/tb_ram_flops_tile.sv

// File: Makefile
# Verilator build and run of the flop RAM tile testbench

TOP := tb_ram_flops_tile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 \
		-f ram_flops_tile.f --top-module $(TOP) -Mdir obj_dir

# A stop on an assertion leaves no closing line in the log and counts as a failure
run: compile
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qF '*** TEST FAILED ***' $(LOG) || ! grep -qF '*** TEST PASSED ***' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf obj_dir $(LOG)

// File: verif/tb_ram_flops_tile.sv
/*
  Testbench for the flop RAM tile
  - clock, reset and a cycle timeout
  - table of directed stimulus with expected read data
  - seeded random phase checked against a reference array
  - one report line per test and a closing summary
*/

`timescale 1ns/1ps
`default_nettype none

module tb_ram_flops_tile
  import ram_tile_pkg::*;
();

  // --------------------------------------------------
  // Run parameters
  // --------------------------------------------------

  localparam int NUM_WR_PORTS   = 2;
  localparam int NUM_RD_PORTS   = 2;
  localparam int RESET_CYCLES   = 3;
  localparam int NUM_ROWS       = 28;
  localparam int RAND_CYCLES    = 40;
  localparam int TIMEOUT_CYCLES = NUM_ROWS + RESET_CYCLES + RAND_CYCLES + 20;
  localparam bit [31:0] RAND_SEED = 32'h758e_853a;

  // A write port with nothing to do
  localparam wr_req_t IDLE_WR = '0;

  // One table row is one clock cycle of stimulus and its expected reads
  typedef struct packed {
    int                                      test;
    logic                                    rst;
    wr_req_t [NUM_WR_PORTS-1:0]              wr;
    logic    [NUM_RD_PORTS-1:0]              rd_vld;
    logic    [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] rd_addr;
    entry_t  [NUM_RD_PORTS-1:0]              exp_data;
  } tbl_row_t;

  // --------------------------------------------------
  // DUT signals and state
  // --------------------------------------------------

  logic                                    wr_clk = 1'b0;
  logic                                    wr_rst;
  wr_req_t [NUM_WR_PORTS-1:0]              wr_req;
  logic    [NUM_RD_PORTS-1:0]              rd_addr_valid;
  logic    [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] rd_addr;
  logic    [NUM_RD_PORTS-1:0]              rd_data_valid;
  entry_t  [NUM_RD_PORTS-1:0]              rd_data;

  tbl_row_t rows [NUM_ROWS];
  int       row_cnt = 0;

  // Reference copy of the array for the random phase
  entry_t ref_mem [DEPTH];

  int n_checks  = 0;
  int n_errors  = 0;
  int cycle_cnt = 0;

  ram_flops_tile i_ram_flops_tile (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr_req        (wr_req),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  // Protocol assertions ride along inside every tile instance
  bind ram_flops_tile ram_flops_tile_chk #(
    .NUM_WR_PORTS (NUM_WR_PORTS),
    .NUM_RD_PORTS (NUM_RD_PORTS)
  ) i_ram_flops_tile_chk (
    .wr_clk        (wr_clk),
    .wr_rst        (wr_rst),
    .wr_req        (wr_req),
    .rd_addr_valid (rd_addr_valid),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid)
  );

  // 100 ns period
  always #50 wr_clk = ~wr_clk;

  always @(posedge wr_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("ERROR: timeout, the run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // --------------------------------------------------
  // Table helpers
  // --------------------------------------------------

  function automatic wr_req_t write_req(
    input logic [ADDR_WIDTH-1:0] addr,
    input word_mask_t            word_en,
    input entry_t                data
  );
    wr_req_t req;
    req.valid   = 1'b1;
    req.addr    = addr;
    req.word_en = word_en;
    req.data    = data;
    return req;
  endfunction

  task automatic add_row(
    input int                    test,
    input logic                  rst,
    input wr_req_t               wr0,
    input wr_req_t               wr1,
    input logic [1:0]            vld,
    input logic [ADDR_WIDTH-1:0] ra0,
    input logic [ADDR_WIDTH-1:0] ra1,
    input entry_t                exp0,
    input entry_t                exp1
  );
    tbl_row_t row;
    row.test        = test;
    row.rst         = rst;
    row.wr[0]       = wr0;
    row.wr[1]       = wr1;
    row.rd_vld      = vld;
    row.rd_addr[0]  = ra0;
    row.rd_addr[1]  = ra1;
    row.exp_data[0] = exp0;
    row.exp_data[1] = exp1;
    if (row_cnt < NUM_ROWS) begin
      rows[row_cnt] = row;
    end
    row_cnt++;
  endtask

  // Expected data comes from the tile rules of zero after reset, masked word
  // updates at the edge and same-cycle bypass of the enabled words
  task automatic load_table();
    // Each port reads every entry once and finds the reset value of zero
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd0, 3'd4, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd1, 3'd5, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd2, 3'd6, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd3, 3'd7, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b01, 3'd4, 3'd5, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b10, 3'd6, 3'd0, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd5, 3'd1, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd6, 3'd2, 32'h0000_0000, 32'h0000_0000);
    add_row(1, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd7, 3'd3, 32'h0000_0000, 32'h0000_0000);

    // Full write to entry 2, visible from the next cycle
    add_row(2, 1'b0, write_req(3'd2, 4'b1111, 32'hA1B2_C3D4), IDLE_WR, 2'b11, 3'd0, 3'd1,
            32'h0000_0000, 32'h0000_0000);
    add_row(2, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd2, 3'd2, 32'hA1B2_C3D4, 32'hA1B2_C3D4);
    add_row(2, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd2, 3'd0, 32'hA1B2_C3D4, 32'h0000_0000);

    // Words 0 and 2 from port 0 and then word 3 from port 1
    add_row(3, 1'b0, write_req(3'd2, 4'b0101, 32'h1122_3344), IDLE_WR, 2'b11, 3'd3, 3'd4,
            32'h0000_0000, 32'h0000_0000);
    add_row(3, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd2, 3'd2, 32'hA122_C344, 32'hA122_C344);
    add_row(3, 1'b0, IDLE_WR, write_req(3'd2, 4'b1000, 32'h5566_7788), 2'b11, 3'd0, 3'd1,
            32'h0000_0000, 32'h0000_0000);
    add_row(3, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd2, 3'd6, 32'h5522_C344, 32'h0000_0000);

    // Same-cycle reads see new enabled words over the old stored ones
    add_row(4, 1'b0, write_req(3'd2, 4'b0011, 32'hDEAD_BEEF), IDLE_WR, 2'b11, 3'd2, 3'd3,
            32'h5522_BEEF, 32'h0000_0000);
    add_row(4, 1'b0, IDLE_WR, write_req(3'd6, 4'b1100, 32'hCAFE_F00D), 2'b11, 3'd2, 3'd6,
            32'h5522_BEEF, 32'hCAFE_0000);
    add_row(4, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd6, 3'd2, 32'hCAFE_0000, 32'h5522_BEEF);

    // Both write ports active on different entries
    add_row(5, 1'b0, write_req(3'd0, 4'b1111, 32'h0123_4567),
            write_req(3'd7, 4'b1111, 32'h89AB_CDEF), 2'b11, 3'd1, 3'd3,
            32'h0000_0000, 32'h0000_0000);
    add_row(5, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd0, 3'd7, 32'h0123_4567, 32'h89AB_CDEF);
    add_row(5, 1'b0, write_req(3'd4, 4'b0110, 32'hFFFF_FFFF),
            write_req(3'd5, 4'b1001, 32'h1234_5678), 2'b11, 3'd7, 3'd0,
            32'h89AB_CDEF, 32'h0123_4567);
    add_row(5, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd4, 3'd5, 32'h00FF_FF00, 32'h1200_0078);

    // Stored data stays readable until the reset edge and then all is zero
    add_row(6, 1'b1, IDLE_WR, IDLE_WR, 2'b11, 3'd0, 3'd7, 32'h0123_4567, 32'h89AB_CDEF);
    add_row(6, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd0, 3'd7, 32'h0000_0000, 32'h0000_0000);
    add_row(6, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd2, 3'd4, 32'h0000_0000, 32'h0000_0000);
    add_row(6, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd5, 3'd6, 32'h0000_0000, 32'h0000_0000);
    add_row(6, 1'b0, IDLE_WR, IDLE_WR, 2'b11, 3'd1, 3'd3, 32'h0000_0000, 32'h0000_0000);

    if (row_cnt != NUM_ROWS) begin
      n_errors++;
      $display("ERROR: stimulus table holds %0d rows instead of %0d", row_cnt, NUM_ROWS);
    end
  endtask

  function automatic string test_name(input int test);
    case (test)
      1:       return "reset reads zero";
      2:       return "full write";
      3:       return "partial write";
      4:       return "write bypass";
      5:       return "dual write ports";
      6:       return "reset in mid-run";
      default: return "random traffic";
    endcase
  endfunction

  // --------------------------------------------------
  // Cycle driver and checks
  // --------------------------------------------------

  task automatic check_outputs(
    input logic   [NUM_RD_PORTS-1:0] exp_vld,
    input entry_t [NUM_RD_PORTS-1:0] exp_data
  );
    for (int p = 0; p < NUM_RD_PORTS; p++) begin
      n_checks++;
      if (rd_data_valid[p] !== exp_vld[p]) begin
        n_errors++;
        $display("MISMATCH at %0t: read port %0d rd_data_valid %b, expected %b",
                 $time, p, rd_data_valid[p], exp_vld[p]);
      end
      // Data of an idle read port carries no meaning
      if (exp_vld[p]) begin
        n_checks++;
        if (rd_data[p] !== exp_data[p]) begin
          n_errors++;
          $display("MISMATCH at %0t: read port %0d rd_data %h, expected %h",
                   $time, p, rd_data[p], exp_data[p]);
        end
      end
    end
  endtask

  task automatic run_cycle(
    input logic                                    rst,
    input wr_req_t [NUM_WR_PORTS-1:0]              wr,
    input logic    [NUM_RD_PORTS-1:0]              vld,
    input logic    [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] addr,
    input entry_t  [NUM_RD_PORTS-1:0]              exp_data
  );
    @(posedge wr_clk);
    #1;
    wr_rst        = rst;
    wr_req        = wr;
    rd_addr_valid = vld;
    rd_addr       = addr;
    // Outputs are sampled 2 ns before the next edge
    #97;
    check_outputs(vld, exp_data);
  endtask

  task automatic report_test(input int test, input int errs);
    $display("Test %0d (%s) done: %0d errors", test, test_name(test), errs);
  endtask

  // --------------------------------------------------
  // Reference model and random phase
  // --------------------------------------------------

  // Stored entry with the enabled words of a matching write laid over it
  function automatic entry_t model_read(
    input logic    [ADDR_WIDTH-1:0]    addr,
    input wr_req_t [NUM_WR_PORTS-1:0]  wr
  );
    entry_t val;
    val = ref_mem[addr];
    for (int w = 0; w < NUM_WR_PORTS; w++) begin
      if (wr[w].valid && (wr[w].addr == addr)) begin
        for (int k = 0; k < NUM_WORDS; k++) begin
          if (wr[w].word_en[k]) begin
            val[k] = wr[w].data[k];
          end
        end
      end
    end
    return val;
  endfunction

  // Mirrors the storage update at the rising edge
  task automatic model_write(input wr_req_t [NUM_WR_PORTS-1:0] wr);
    for (int w = 0; w < NUM_WR_PORTS; w++) begin
      for (int k = 0; k < NUM_WORDS; k++) begin
        if (wr[w].valid && wr[w].word_en[k]) begin
          ref_mem[wr[w].addr][k] = wr[w].data[k];
        end
      end
    end
  endtask

  task automatic run_random();
    wr_req_t [NUM_WR_PORTS-1:0]              wr;
    logic    [NUM_RD_PORTS-1:0]              vld;
    logic    [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] addr;
    entry_t  [NUM_RD_PORTS-1:0]              exp_data;
    logic    [ADDR_WIDTH-1:0]                base;
    for (int c = 0; c < RAND_CYCLES; c++) begin
      // Port 1 sits 1 to DEPTH-1 entries past port 0, so they never collide
      base        = ADDR_WIDTH'($urandom % DEPTH);
      wr[0].addr  = base;
      wr[1].addr  = ADDR_WIDTH'(int'(base) + 1 + int'($urandom % (DEPTH - 1)));
      for (int w = 0; w < NUM_WR_PORTS; w++) begin
        wr[w].valid   = 1'($urandom);
        wr[w].word_en = word_mask_t'($urandom);
        wr[w].data    = $urandom;
      end
      vld = NUM_RD_PORTS'($urandom);
      for (int r = 0; r < NUM_RD_PORTS; r++) begin
        addr[r]     = ADDR_WIDTH'($urandom);
        exp_data[r] = model_read(addr[r], wr);
      end
      run_cycle(1'b0, wr, vld, addr, exp_data);
      model_write(wr);
    end
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------

  initial begin
    int err_start;
    void'($urandom(RAND_SEED));
    wr_rst        = 1'b1;
    wr_req        = '0;
    rd_addr_valid = '0;
    rd_addr       = '0;
    for (int a = 0; a < DEPTH; a++) begin
      ref_mem[a] = '0;
    end
    load_table();

    repeat (RESET_CYCLES) @(posedge wr_clk);
    #1;
    wr_rst = 1'b0;

    // Rows are grouped by test and kept in table order
    for (int t = 1; t <= 6; t++) begin
      err_start = n_errors;
      for (int i = 0; i < NUM_ROWS; i++) begin
        if (rows[i].test == t) begin
          run_cycle(rows[i].rst, rows[i].wr, rows[i].rd_vld, rows[i].rd_addr,
                    rows[i].exp_data);
        end
      end
      report_test(t, n_errors - err_start);
    end

    // The table ends after a reset with no writes, so the array is all zero
    err_start = n_errors;
    run_random();
    report_test(7, n_errors - err_start);

    $display("Summary: 7 tests, %0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/ram_flops_tile_chk.sv
/*
  Concurrent assertions for the flop RAM tile
  - no two valid write ports on one address
  - write and read addresses inside the array
  - read data valid follows the read address valid
*/

`timescale 1ns/1ps
`default_nettype none

module ram_flops_tile_chk
  import ram_tile_pkg::*;
#(
  parameter int NUM_WR_PORTS = 2,
  parameter int NUM_RD_PORTS = 2
) (
  input  logic                                   wr_clk,
  input  logic                                   wr_rst,
  input  wr_req_t [NUM_WR_PORTS-1:0]             wr_req,
  input  logic    [NUM_RD_PORTS-1:0]             rd_addr_valid,
  input  logic    [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] rd_addr,
  input  logic    [NUM_RD_PORTS-1:0]             rd_data_valid
);

  // --------------------------------------------------
  // Write ports
  // --------------------------------------------------

  for (genvar a = 0; a < NUM_WR_PORTS; a++) begin : gen_wr
    // The tile has no arbitration, every pair must stay apart
    for (genvar b = a + 1; b < NUM_WR_PORTS; b++) begin : gen_pair
      a_wr_addr_unique : assert property (@(posedge wr_clk) disable iff (wr_rst)
        (wr_req[a].valid && wr_req[b].valid) |-> (wr_req[a].addr != wr_req[b].addr))
      else $error("Write ports %0d and %0d target the same address", a, b);
    end

    a_wr_addr_range : assert property (@(posedge wr_clk) disable iff (wr_rst)
      wr_req[a].valid |-> (int'(wr_req[a].addr) < DEPTH))
    else $error("Write port %0d address beyond the array", a);
  end

  // --------------------------------------------------
  // Read ports
  // --------------------------------------------------

  for (genvar r = 0; r < NUM_RD_PORTS; r++) begin : gen_rd
    a_rd_addr_range : assert property (@(posedge wr_clk) disable iff (wr_rst)
      rd_addr_valid[r] |-> (int'(rd_addr[r]) < DEPTH))
    else $error("Read port %0d address beyond the array", r);

    // Zero-latency read, so the valid holds in the very same cycle
    a_rd_valid_follows : assert property (@(posedge wr_clk)
      rd_addr_valid[r] |-> rd_data_valid[r])
    else $error("Read port %0d lost rd_data_valid", r);
  end

endmodule

`default_nettype wire

// File: hw/ram_flops_tile.sv
/*
  Top level of the flop RAM tile
  - write decode into per-row commands
  - flop storage with reset clear
  - one combinational read port per read address
  Writes land at the next rising edge; reads have zero latency.
*/

`timescale 1ns/1ps
`default_nettype none

module ram_flops_tile
  import ram_tile_pkg::*;
#(
  parameter int NUM_WR_PORTS  = 2,
  parameter int NUM_RD_PORTS  = 2,
  parameter bit ENABLE_BYPASS = 1'b1
) (
  input  logic                                   wr_clk,
  input  logic                                   wr_rst,

  // Write ports, at most one valid port per address in any cycle
  input  wr_req_t [NUM_WR_PORTS-1:0]             wr_req,

  // Read ports
  input  logic    [NUM_RD_PORTS-1:0]             rd_addr_valid,
  input  logic    [NUM_RD_PORTS-1:0][ADDR_WIDTH-1:0] rd_addr,
  output logic    [NUM_RD_PORTS-1:0]             rd_data_valid,
  output entry_t  [NUM_RD_PORTS-1:0]             rd_data
);

  // --------------------------------------------------
  // Internal nets
  // --------------------------------------------------

  // Decoded write command for each storage row
  row_wr_t [DEPTH-1:0] row_wr;

  // Current contents of the whole array
  entry_t [DEPTH-1:0] mem;

  // --------------------------------------------------
  // Write path
  // --------------------------------------------------

  ram_wr_decode #(
    .NUM_WR_PORTS (NUM_WR_PORTS)
  ) i_ram_wr_decode (
    .wr_req (wr_req),
    .row_wr (row_wr)
  );

  ram_storage i_ram_storage (
    .wr_clk (wr_clk),
    .wr_rst (wr_rst),
    .row_wr (row_wr),
    .mem    (mem)
  );

  // --------------------------------------------------
  // Read path
  // --------------------------------------------------

  // Every read port sees the full array and all write ports
  for (genvar rport = 0; rport < NUM_RD_PORTS; rport++) begin : gen_rd_port
    ram_rd_port #(
      .NUM_WR_PORTS  (NUM_WR_PORTS),
      .ENABLE_BYPASS (ENABLE_BYPASS)
    ) i_ram_rd_port (
      .wr_req  (wr_req),
      .mem     (mem),
      .rd_addr (rd_addr[rport]),
      .rd_data (rd_data[rport])
    );
  end

  // Read data is valid in the same cycle as the address
  assign rd_data_valid = rd_addr_valid;

endmodule

`default_nettype wire

// File: hw/ram_rd_port.sv
/*
  One combinational read port of the RAM tile
  - address mux over the stored entries
  - optional write-to-read bypass, merged word by word
*/

`timescale 1ns/1ps
`default_nettype none

module ram_rd_port
  import ram_tile_pkg::*;
#(
  parameter int NUM_WR_PORTS  = 2,
  parameter bit ENABLE_BYPASS = 1'b1
) (
  input  wr_req_t [NUM_WR_PORTS-1:0] wr_req,
  input  entry_t  [DEPTH-1:0]        mem,
  input  logic    [ADDR_WIDTH-1:0]   rd_addr,
  output entry_t                     rd_data
);

  // --------------------------------------------------
  // Array read
  // --------------------------------------------------

  // Stored value of the addressed entry, before any bypass
  entry_t rd_data_mem;

  assign rd_data_mem = mem[rd_addr];

  // --------------------------------------------------
  // Bypass merge
  // --------------------------------------------------

  if (ENABLE_BYPASS) begin : gen_bypass
    // Write ports hitting this read address in the current cycle
    logic [NUM_WR_PORTS-1:0] wr_match;
    // Data and mask of the matching port, zero when nothing matches
    entry_t     byp_data;
    word_mask_t byp_word_en;

    for (genvar port = 0; port < NUM_WR_PORTS; port++) begin : gen_match
      assign wr_match[port] = wr_req[port].valid && (wr_req[port].addr == rd_addr);
    end

    // At most one port can match since write addresses never collide,
    // so a plain AND-OR picks the hitting port
    always_comb begin
      byp_data    = '0;
      byp_word_en = '0;
      for (int port = 0; port < NUM_WR_PORTS; port++) begin
        byp_data    = byp_data | ({WIDTH{wr_match[port]}} & wr_req[port].data);
        byp_word_en = byp_word_en | ({NUM_WORDS{wr_match[port]}} & wr_req[port].word_en);
      end
    end

    // The mask is already zero without a match, so it alone picks the source
    for (genvar word = 0; word < NUM_WORDS; word++) begin : gen_word
      assign rd_data[word] = byp_word_en[word] ? byp_data[word] : rd_data_mem[word];
    end
  end else begin : gen_no_bypass
    // Writes in this cycle become visible only after the next edge
    assign rd_data = rd_data_mem;
  end

endmodule

`default_nettype wire

// File: hw/ram_storage.sv
/*
  Flop storage array of the RAM tile
  - DEPTH entries of NUM_WORDS words each
  - word-granular load from the decoded row commands
  - synchronous clear of every entry on reset
*/

`timescale 1ns/1ps
`default_nettype none

module ram_storage
  import ram_tile_pkg::*;
(
  input  logic                 wr_clk,
  input  logic                 wr_rst,
  input  row_wr_t [DEPTH-1:0]  row_wr,
  output entry_t  [DEPTH-1:0]  mem
);

  // --------------------------------------------------
  // Word load enables
  // --------------------------------------------------

  // A word loads only when its row is written and its mask bit is set
  logic [DEPTH-1:0][NUM_WORDS-1:0] word_ld;

  for (genvar row = 0; row < DEPTH; row++) begin : gen_row
    for (genvar word = 0; word < NUM_WORDS; word++) begin : gen_word
      assign word_ld[row][word] = row_wr[row].en && row_wr[row].word_en[word];
    end
  end

  // --------------------------------------------------
  // Storage flops
  // --------------------------------------------------

  // Reset wins over any write in the same cycle
  always_ff @(posedge wr_clk) begin
    if (wr_rst) begin
      mem <= '0;
    end else begin
      for (int row = 0; row < DEPTH; row++) begin
        for (int word = 0; word < NUM_WORDS; word++) begin
          // Words without a load keep their value
          if (word_ld[row][word]) begin
            mem[row][word] <= row_wr[row].data[word];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ram_wr_decode.sv
/*
  Write-port decoder for the flop RAM tile
  - one-hot row select per valid write port
  - transpose of the select so it is grouped by row
  - per-row enable, data and word mask via an AND-OR mux
*/

`timescale 1ns/1ps
`default_nettype none

module ram_wr_decode
  import ram_tile_pkg::*;
#(
  parameter int NUM_WR_PORTS = 2
) (
  input  wr_req_t [NUM_WR_PORTS-1:0] wr_req,
  output row_wr_t [DEPTH-1:0]        row_wr
);

  // --------------------------------------------------
  // Address decode
  // --------------------------------------------------

  // Row select, indexed port first
  logic [NUM_WR_PORTS-1:0][DEPTH-1:0] wr_sel;

  // Same select indexed row first, so each row sees which ports hit it
  logic [DEPTH-1:0][NUM_WR_PORTS-1:0] wr_sel_by_row;

  for (genvar port = 0; port < NUM_WR_PORTS; port++) begin : gen_port
    for (genvar row = 0; row < DEPTH; row++) begin : gen_row
      // A port selects a row only while its request is valid
      assign wr_sel[port][row] =
          wr_req[port].valid && (wr_req[port].addr == ADDR_WIDTH'(row));

      assign wr_sel_by_row[row][port] = wr_sel[port][row];
    end
  end

  // --------------------------------------------------
  // Per-row command
  // --------------------------------------------------

  // Ports never share an address in one cycle, so at most one select bit
  // per row is set and the OR of the masked inputs is the selected port
  always_comb begin
    for (int row = 0; row < DEPTH; row++) begin
      row_wr[row].en      = |wr_sel_by_row[row];
      row_wr[row].word_en = '0;
      row_wr[row].data    = '0;

      for (int port = 0; port < NUM_WR_PORTS; port++) begin
        // Mask each port's fields with its select bit and fold them in
        row_wr[row].word_en = row_wr[row].word_en |
            ({NUM_WORDS{wr_sel_by_row[row][port]}} & wr_req[port].word_en);
        row_wr[row].data = row_wr[row].data |
            ({WIDTH{wr_sel_by_row[row][port]}} & wr_req[port].data);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/ram_tile_pkg.sv
/*
  Shared definitions for the flop RAM tile:
  - memory geometry (depth, entry width, word width)
  - derived word count and address width
  - word, entry and word-mask types
  - packed write-port request and per-row write command
*/

`default_nettype none

package ram_tile_pkg;

  // --------------------------------------------------
  // Geometry
  // --------------------------------------------------

  // Number of entries held in the tile
  localparam int DEPTH = 8;

  // Width of one entry in bits
  localparam int WIDTH = 32;

  // Smallest unit that a partial write can change
  localparam int WORD_WIDTH = 8;

  // Words per entry, WIDTH must divide evenly by WORD_WIDTH
  localparam int NUM_WORDS = WIDTH / WORD_WIDTH;

  // Address bits needed to reach every entry
  localparam int ADDR_WIDTH = $clog2(DEPTH);

  // --------------------------------------------------
  // Data types
  // --------------------------------------------------

  typedef logic [WORD_WIDTH-1:0] word_t;

  // Word 0 sits in the low bits of the entry
  typedef word_t [NUM_WORDS-1:0] entry_t;

  // One enable bit per word, bit i gates word i
  typedef logic [NUM_WORDS-1:0] word_mask_t;

  // One write port as seen at the tile boundary
  typedef struct packed {
    logic                  valid;
    logic [ADDR_WIDTH-1:0] addr;
    word_mask_t            word_en;
    entry_t                data;
  } wr_req_t;

  // Write command for a single storage row, already decoded from the ports
  typedef struct packed {
    logic       en;
    word_mask_t word_en;
    entry_t     data;
  } row_wr_t;

endpackage

`default_nettype wire
